// File: verilog/wide_mem_defines.svh
// wide memory subsystem sizing macros
// bank count, lane count, bank row width and request FIFO depth,
// plus the widths derived from them

`ifndef WIDE_MEM_DEFINES_SVH
`define WIDE_MEM_DEFINES_SVH

// number of word-interleaved banks, power of two
`define WM_NB_BANKS 8

// 32-bit lanes in one wide word
`define WM_NB_LANES 4

// bank row address width, 256 words per bank
`define WM_ROW_AW 8

// request FIFO entries
`define WM_FIFO_DEPTH 2

// bank index bits taken from the address above the byte offset
`define WM_BANK_IDX_W ($clog2(`WM_NB_BANKS))

// byte address width: row bits, bank index bits and byte offset
`define WM_ADDR_W (`WM_ROW_AW + `WM_BANK_IDX_W + 2)

`endif

// File: verilog/wide_mem_pkg.sv
// wide memory subsystem types
// vector typedefs shared by the RTL and the testbench

`include "wide_mem_defines.svh"

package wide_mem_pkg;

  // one 32-bit lane, also one bank word
  typedef logic [31:0] word_t;

  // full wide word and its byte enables
  typedef logic [`WM_NB_LANES*32-1:0] wide_data_t;
  typedef logic [`WM_NB_LANES*4-1:0]  wide_be_t;

  // byte enables of a single lane
  typedef logic [3:0] lane_be_t;

  // byte address seen on the request port
  typedef logic [`WM_ADDR_W-1:0] addr_t;

  // word address inside one bank
  typedef logic [`WM_ROW_AW-1:0] row_addr_t;

  // bank selector
  typedef logic [`WM_BANK_IDX_W-1:0] bank_idx_t;

endpackage

// File: verilog/wide_req_fifo.sv
// wide request FIFO
// circular buffer holding address, write enable, byte enables and data
// of wide requests in front of the router

`timescale 1ns/1ns
`include "wide_mem_defines.svh"

module wide_req_fifo #(
  parameter int unsigned DEPTH = `WM_FIFO_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     push_i,
  input  wide_mem_pkg::addr_t      add_i,
  input  logic                     wen_i,
  input  wide_mem_pkg::wide_be_t   be_i,
  input  wide_mem_pkg::wide_data_t data_i,
  input  logic                     pop_i,
  output logic                     full_o,
  output logic                     valid_o,
  output wide_mem_pkg::addr_t      add_o,
  output logic                     wen_o,
  output wide_mem_pkg::wide_be_t   be_o,
  output wide_mem_pkg::wide_data_t data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // payload storage
  wide_mem_pkg::addr_t      add_mem  [DEPTH];
  logic                     wen_mem  [DEPTH];
  wide_mem_pkg::wide_be_t   be_mem   [DEPTH];
  wide_mem_pkg::wide_data_t data_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // wrap at DEPTH so non power-of-two depths work too
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);

  // a push while full is dropped, the requester sees gnt low
  assign push = push_i & ~full_o;
  assign pop  = pop_i & valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // count only moves when exactly one side is active
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      add_mem[wr_ptr_q]  <= add_i;
      wen_mem[wr_ptr_q]  <= wen_i;
      be_mem[wr_ptr_q]   <= be_i;
      data_mem[wr_ptr_q] <= data_i;
    end
  end

  // head of the queue, valid one cycle after the push
  assign add_o  = add_mem[rd_ptr_q];
  assign wen_o  = wen_mem[rd_ptr_q];
  assign be_o   = be_mem[rd_ptr_q];
  assign data_o = data_mem[rd_ptr_q];

endmodule

// File: verilog/router_reorder.sv
// lane to bank rotation for the shallow router
// lane k goes to bank (offset + k) mod bank count, ready bits and read
// data are rotated back to lane order

`timescale 1ns/1ns
`include "wide_mem_defines.svh"

module router_reorder (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  input  logic                                        issue_i,
  input  wide_mem_pkg::bank_idx_t                     offset_i,
  input  logic [`WM_NB_LANES-1:0]                     lane_req_i,
  input  logic [`WM_NB_LANES-1:0]                     lane_wen_i,
  input  wide_mem_pkg::lane_be_t [`WM_NB_LANES-1:0]   lane_be_i,
  input  wide_mem_pkg::word_t [`WM_NB_LANES-1:0]      lane_data_i,
  input  wide_mem_pkg::row_addr_t [`WM_NB_LANES-1:0]  lane_row_i,
  output wide_mem_pkg::word_t [`WM_NB_LANES-1:0]      lane_rdata_o,
  output logic [`WM_NB_LANES-1:0]                     bank_ready_o,
  output logic [`WM_NB_BANKS-1:0]                     bank_req_o,
  output logic [`WM_NB_BANKS-1:0]                     bank_wen_o,
  output wide_mem_pkg::lane_be_t [`WM_NB_BANKS-1:0]   bank_be_o,
  output wide_mem_pkg::word_t [`WM_NB_BANKS-1:0]      bank_data_o,
  output wide_mem_pkg::row_addr_t [`WM_NB_BANKS-1:0]  bank_row_o,
  input  logic [`WM_NB_BANKS-1:0]                     bank_ready_i,
  input  wide_mem_pkg::word_t [`WM_NB_BANKS-1:0]      bank_rdata_i
);

  wide_mem_pkg::bank_idx_t                      offset_q;
  wide_mem_pkg::bank_idx_t [`WM_NB_LANES-1:0]   fwd_bank;
  wide_mem_pkg::bank_idx_t [`WM_NB_LANES-1:0]   ret_bank;

  // truncation to the index width gives the modulo for free
  for (genvar k = 0; k < `WM_NB_LANES; k++) begin : gen_rot
    assign fwd_bank[k]     = offset_i + wide_mem_pkg::bank_idx_t'(k);
    assign ret_bank[k]     = offset_q + wide_mem_pkg::bank_idx_t'(k);
    assign bank_ready_o[k] = bank_ready_i[fwd_bank[k]];
    // read data belongs to the access issued last cycle
    assign lane_rdata_o[k] = bank_rdata_i[ret_bank[k]];
  end

  // forward path, untargeted banks stay idle
  always_comb begin
    bank_req_o  = '0;
    bank_wen_o  = '1;
    bank_be_o   = '0;
    bank_data_o = '0;
    bank_row_o  = '0;
    for (int k = 0; k < `WM_NB_LANES; k++) begin
      bank_req_o[fwd_bank[k]]  = lane_req_i[k];
      bank_wen_o[fwd_bank[k]]  = lane_wen_i[k];
      bank_be_o[fwd_bank[k]]   = lane_be_i[k];
      bank_data_o[fwd_bank[k]] = lane_data_i[k];
      bank_row_o[fwd_bank[k]]  = lane_row_i[k];
    end
  end

  // offset of the issued access, kept for the return path
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (clear_i) begin
      offset_q <= '0;
    end else if (issue_i) begin
      offset_q <= offset_i;
    end
  end

endmodule

// File: verilog/wide_router.sv
// shallow wide-to-bank router
// splits the FIFO head into 32-bit lanes, computes each lane's bank row,
// issues only when all targeted banks are ready and rebuilds the response

`timescale 1ns/1ns
`include "wide_mem_defines.svh"

module wide_router (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  input  logic                                        head_valid_i,
  input  wide_mem_pkg::addr_t                         head_add_i,
  input  logic                                        head_wen_i,
  input  wide_mem_pkg::wide_be_t                      head_be_i,
  input  wide_mem_pkg::wide_data_t                    head_data_i,
  output logic                                        pop_o,
  output logic                                        r_valid_o,
  output wide_mem_pkg::wide_data_t                    r_data_o,
  output logic [`WM_NB_BANKS-1:0]                     bank_req_o,
  output logic [`WM_NB_BANKS-1:0]                     bank_wen_o,
  output wide_mem_pkg::lane_be_t [`WM_NB_BANKS-1:0]   bank_be_o,
  output wide_mem_pkg::word_t [`WM_NB_BANKS-1:0]      bank_data_o,
  output wide_mem_pkg::row_addr_t [`WM_NB_BANKS-1:0]  bank_row_o,
  input  logic [`WM_NB_BANKS-1:0]                     bank_ready_i,
  input  wide_mem_pkg::word_t [`WM_NB_BANKS-1:0]      bank_rdata_i
);

  // row bits start above the bank index and the byte offset
  localparam int unsigned ROW_LSB = `WM_BANK_IDX_W + 2;
  // one extra bit to see the wrap past the last bank
  localparam int unsigned SUM_W   = `WM_BANK_IDX_W + 1;

  wide_mem_pkg::bank_idx_t                            offset;
  wide_mem_pkg::row_addr_t                            base_row;
  logic [`WM_NB_LANES-1:0]                            lane_req;
  logic [`WM_NB_LANES-1:0]                            lane_wen;
  logic [`WM_NB_LANES-1:0]                            lane_ready;
  wide_mem_pkg::lane_be_t [`WM_NB_LANES-1:0]          lane_be;
  wide_mem_pkg::word_t [`WM_NB_LANES-1:0]             lane_data;
  wide_mem_pkg::row_addr_t [`WM_NB_LANES-1:0]         lane_row;
  wide_mem_pkg::word_t [`WM_NB_LANES-1:0]             lane_rdata;
  logic                                               issue;
  logic                                               issued_q;

  assign offset   = head_add_i[ROW_LSB-1:2];
  assign base_row = head_add_i[`WM_ADDR_W-1:ROW_LSB];

  for (genvar k = 0; k < `WM_NB_LANES; k++) begin : gen_lane
    logic [SUM_W-1:0] bank_sum;

    assign bank_sum = {1'b0, offset} + SUM_W'(k);

    // lanes that wrap past bank 7 land on the next row
    assign lane_row[k] = (bank_sum >= SUM_W'(`WM_NB_BANKS)) ?
                         base_row + wide_mem_pkg::row_addr_t'(1) : base_row;

    assign lane_req[k]  = issue;
    assign lane_wen[k]  = head_wen_i;
    assign lane_be[k]   = head_be_i[4*k +: 4];
    assign lane_data[k] = head_data_i[32*k +: 32];

    // lane k is the k-th word of the wide response
    assign r_data_o[32*k +: 32] = lane_rdata[k];
  end

  // all-or-nothing issue, never a partial access
  assign issue = head_valid_i & (&lane_ready);
  assign pop_o = issue;

  // banks answer exactly one cycle after issue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= 1'b0;
    end else if (clear_i) begin
      issued_q <= 1'b0;
    end else begin
      issued_q <= issue;
    end
  end

  assign r_valid_o = issued_q;

  router_reorder u_router_reorder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .issue_i      ( issue        ),
    .offset_i     ( offset       ),
    .lane_req_i   ( lane_req     ),
    .lane_wen_i   ( lane_wen     ),
    .lane_be_i    ( lane_be      ),
    .lane_data_i  ( lane_data    ),
    .lane_row_i   ( lane_row     ),
    .lane_rdata_o ( lane_rdata   ),
    .bank_ready_o ( lane_ready   ),
    .bank_req_o   ( bank_req_o   ),
    .bank_wen_o   ( bank_wen_o   ),
    .bank_be_o    ( bank_be_o    ),
    .bank_data_o  ( bank_data_o  ),
    .bank_row_o   ( bank_row_o   ),
    .bank_ready_i ( bank_ready_i ),
    .bank_rdata_i ( bank_rdata_i )
  );

endmodule

// File: verilog/tcdm_bank.sv
// single 32-bit TCDM bank
// word-addressed array with byte-masked writes, a stall input and a
// registered read port answering one cycle after the request

`timescale 1ns/1ns
`include "wide_mem_defines.svh"

module tcdm_bank (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    wen_i,
  input  wide_mem_pkg::lane_be_t  be_i,
  input  wide_mem_pkg::word_t     data_i,
  input  wide_mem_pkg::row_addr_t row_i,
  input  logic                    stall_i,
  output logic                    ready_o,
  output wide_mem_pkg::word_t     rdata_o
);

  localparam int unsigned NB_ROWS = 2 ** `WM_ROW_AW;

  wide_mem_pkg::word_t mem_q [NB_ROWS];
  logic                access;

  assign ready_o = ~stall_i;
  // a stalled bank ignores requests
  assign access  = req_i & ready_o;

  // wen low means write, only enabled bytes change
  always_ff @(posedge clk_i) begin
    if (access && !wen_i) begin
      for (int i = 0; i < 4; i++) begin
        if (be_i[i]) begin
          mem_q[row_i][8*i +: 8] <= data_i[8*i +: 8];
        end
      end
    end
  end

  // every access returns the word as it was before the write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (access) begin
      rdata_o <= mem_q[row_i];
    end
  end

endmodule

// File: verilog/wide_mem_subsystem.sv
// wide-port memory subsystem
// one 128-bit request port, a request FIFO and a shallow router in front
// of eight word-interleaved 32-bit banks

`timescale 1ns/1ns
`include "wide_mem_defines.svh"

module wide_mem_subsystem (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     req_i,
  input  logic                     wen_i,
  input  wide_mem_pkg::addr_t      add_i,
  input  wide_mem_pkg::wide_be_t   be_i,
  input  wide_mem_pkg::wide_data_t data_i,
  input  logic [`WM_NB_BANKS-1:0]  bank_stall_i,
  output logic                     gnt_o,
  output logic                     r_valid_o,
  output wide_mem_pkg::wide_data_t r_data_o
);

  // FIFO head
  logic                                        fifo_full;
  logic                                        head_valid;
  wide_mem_pkg::addr_t                         head_add;
  logic                                        head_wen;
  wide_mem_pkg::wide_be_t                      head_be;
  wide_mem_pkg::wide_data_t                    head_data;
  logic                                        pop;

  // router to banks
  logic [`WM_NB_BANKS-1:0]                     bank_req;
  logic [`WM_NB_BANKS-1:0]                     bank_wen;
  wide_mem_pkg::lane_be_t [`WM_NB_BANKS-1:0]   bank_be;
  wide_mem_pkg::word_t [`WM_NB_BANKS-1:0]      bank_data;
  wide_mem_pkg::row_addr_t [`WM_NB_BANKS-1:0]  bank_row;
  logic [`WM_NB_BANKS-1:0]                     bank_ready;
  wide_mem_pkg::word_t [`WM_NB_BANKS-1:0]      bank_rdata;

  // grant as long as there is room, independent of req_i
  assign gnt_o = ~fifo_full;

  wide_req_fifo #(
    .DEPTH ( `WM_FIFO_DEPTH )
  ) u_wide_req_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .clear_i ( clear_i    ),
    .push_i  ( req_i      ),
    .add_i   ( add_i      ),
    .wen_i   ( wen_i      ),
    .be_i    ( be_i       ),
    .data_i  ( data_i     ),
    .pop_i   ( pop        ),
    .full_o  ( fifo_full  ),
    .valid_o ( head_valid ),
    .add_o   ( head_add   ),
    .wen_o   ( head_wen   ),
    .be_o    ( head_be    ),
    .data_o  ( head_data  )
  );

  wide_router u_wide_router (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .head_valid_i ( head_valid ),
    .head_add_i   ( head_add   ),
    .head_wen_i   ( head_wen   ),
    .head_be_i    ( head_be    ),
    .head_data_i  ( head_data  ),
    .pop_o        ( pop        ),
    .r_valid_o    ( r_valid_o  ),
    .r_data_o     ( r_data_o   ),
    .bank_req_o   ( bank_req   ),
    .bank_wen_o   ( bank_wen   ),
    .bank_be_o    ( bank_be    ),
    .bank_data_o  ( bank_data  ),
    .bank_row_o   ( bank_row   ),
    .bank_ready_i ( bank_ready ),
    .bank_rdata_i ( bank_rdata )
  );

  for (genvar b = 0; b < `WM_NB_BANKS; b++) begin : gen_bank
    tcdm_bank u_tcdm_bank (
      .clk_i   ( clk_i           ),
      .rst_ni  ( rst_ni          ),
      .req_i   ( bank_req[b]     ),
      .wen_i   ( bank_wen[b]     ),
      .be_i    ( bank_be[b]      ),
      .data_i  ( bank_data[b]    ),
      .row_i   ( bank_row[b]     ),
      .stall_i ( bank_stall_i[b] ),
      .ready_o ( bank_ready[b]   ),
      .rdata_o ( bank_rdata[b]   )
    );
  end

endmodule

// File: dv/wide_mem_sva.sv
// wide memory subsystem assertions
// reset behavior, response count against acceptances and grant
// while the request FIFO is full

`timescale 1ns/1ns
`include "wide_mem_defines.svh"

module wide_mem_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic req_i,
  input logic gnt_i,
  input logic r_valid_i
);

  int unsigned acc_cnt;
  int unsigned resp_cnt;

  // running totals of accepted requests and returned responses
  // a clear drops whatever is still queued or in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_cnt  <= 0;
      resp_cnt <= 0;
    end else if (clear_i) begin
      acc_cnt  <= 0;
      resp_cnt <= 0;
    end else begin
      if (req_i && gnt_i) begin
        acc_cnt <= acc_cnt + 1;
      end
      if (r_valid_i) begin
        resp_cnt <= resp_cnt + 1;
      end
    end
  end

  // no response while reset is held
  assert property (@(posedge clk_i) !rst_ni |-> !r_valid_i)
    else $error("r_valid_o high during reset");

  // every response needs an acceptance not yet answered
  assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid_i |-> (resp_cnt < acc_cnt))
    else $error("more responses than accepted requests");

  // FIFO entries are acceptances not yet issued, the issued one shows as r_valid_o
  // an acceptance needs at least one of them free
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (req_i && gnt_i) |->
                   ((acc_cnt - resp_cnt - 32'(r_valid_i)) < `WM_FIFO_DEPTH))
    else $error("gnt_o high while the request FIFO is full");

endmodule

bind wide_mem_subsystem wide_mem_sva u_wide_mem_sva (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .clear_i   ( clear_i   ),
  .req_i     ( req_i     ),
  .gnt_i     ( gnt_o     ),
  .r_valid_i ( r_valid_o )
);

// File: dv/tb_wide_mem.sv
// wide memory subsystem testbench
// directed and random wide accesses checked against a shadow word memory,
// responses compared in order with the expected queue

`timescale 1ns/1ns
`include "wide_mem_defines.svh"

module tb_wide_mem;

  localparam int unsigned NB_WORDS    = `WM_NB_BANKS * (2 ** `WM_ROW_AW);
  localparam int unsigned NB_RAND     = 60;
  // directed requests plus prefill plus random burst
  localparam int unsigned NB_REQ      = 43 + NB_RAND;
  localparam int unsigned TIMEOUT_CYC = NB_REQ * 40 + 8 + 200;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     clear_i;
  logic                     req_i;
  logic                     wen_i;
  wide_mem_pkg::addr_t      add_i;
  wide_mem_pkg::wide_be_t   be_i;
  wide_mem_pkg::wide_data_t data_i;
  logic [`WM_NB_BANKS-1:0]  bank_stall_i = '0;
  logic                     gnt_o;
  logic                     r_valid_o;
  wide_mem_pkg::wide_data_t r_data_o;

  wide_mem_pkg::word_t      shadow [NB_WORDS];
  logic                     exp_rd_q [$];
  wide_mem_pkg::wide_data_t exp_data_q [$];
  logic [31:0]              rng_state = 32'h5ecc_c7c4;
  logic [31:0]              stall_state = 32'h5ecc_c7c4;
  logic                     stall_en = 1'b0;
  int unsigned              errors = 0;
  int unsigned              n_checks = 0;

  wide_mem_subsystem u_wide_mem_subsystem (.*);

  always #10 clk_i = ~clk_i;

  // one LCG step
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  function automatic wide_mem_pkg::wide_data_t rand_wide();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // lane k of a request at word w is global word w+k
  function automatic wide_mem_pkg::wide_data_t ref_read(input int unsigned w);
    wide_mem_pkg::wide_data_t d;
    for (int k = 0; k < `WM_NB_LANES; k++) begin
      d[32*k +: 32] = shadow[(w + k) % NB_WORDS];
    end
    return d;
  endfunction

  function automatic void ref_write(input int unsigned w, input wide_mem_pkg::wide_be_t be,
                                    input wide_mem_pkg::wide_data_t d);
    for (int k = 0; k < `WM_NB_LANES; k++) begin
      for (int b = 0; b < 4; b++) begin
        if (be[4*k+b]) begin
          shadow[(w + k) % NB_WORDS][8*b +: 8] = d[32*k+8*b +: 8];
        end
      end
    end
  endfunction

  // called on a falling edge, returns one falling edge after acceptance
  task automatic send_req(input logic rd, input int unsigned w,
                          input wide_mem_pkg::wide_be_t be, input wide_mem_pkg::wide_data_t d);
    req_i  = 1'b1;
    wen_i  = rd;
    add_i  = wide_mem_pkg::addr_t'(w * 4);
    be_i   = be;
    data_i = d;
    // gnt_o only moves on the rising edge
    while (!gnt_o) @(negedge clk_i);
    exp_rd_q.push_back(rd);
    if (rd) begin
      exp_data_q.push_back(ref_read(w));
    end else begin
      ref_write(w, be, d);
      exp_data_q.push_back('0);
    end
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_rd_q.size() != 0) @(negedge clk_i);
  endtask

  // random bank stalls, about one bank in four, on a stream of their own
  always @(negedge clk_i) begin : stall_gen
    stall_state  = lcg_step(stall_state);
    bank_stall_i = stall_en ? (stall_state[31:24] & stall_state[23:16]) : '0;
  end

  // in-order response checker, outputs are register driven and stable here
  always @(negedge clk_i) begin : resp_check
    logic                     rd;
    wide_mem_pkg::wide_data_t exp;
    if (rst_ni && r_valid_o) begin
      if (exp_rd_q.size() == 0) begin
        errors++;
        $display("response without an outstanding request at %0t", $time);
      end else begin
        rd  = exp_rd_q.pop_front();
        exp = exp_data_q.pop_front();
        if (rd) begin
          n_checks++;
          if (r_data_o !== exp) begin
            errors++;
            $display("Mismatch r_data_o: expected %h, got %h", exp, r_data_o);
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, responses still missing", TIMEOUT_CYC);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    logic [31:0] r;
    int unsigned w;
    int unsigned wait_cyc;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    req_i   = 1'b0;
    wen_i   = 1'b1;
    add_i   = '0;
    be_i    = '0;
    data_i  = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // aligned write and read back at offset 0
    send_req(1'b0, 0, '1, rand_wide());
    send_req(1'b1, 0, '0, '0);

    // unaligned writes at offsets 5 to 7 wrap onto row 3
    for (int i = 0; i < 4; i++) send_req(1'b0, 16 + 4 * i, '1, rand_wide());
    for (int off = 5; off < 8; off++) send_req(1'b0, 16 + off, '1, rand_wide());
    for (int off = 5; off < 8; off++) send_req(1'b1, 16 + off, '0, '0);
    send_req(1'b1, 24, '0, '0);
    send_req(1'b1, 20, '0, '0);

    // partial byte enables
    send_req(1'b0, 32, '1, rand_wide());
    send_req(1'b0, 32, 16'h5a3c, rand_wide());
    send_req(1'b1, 32, '0, '0);

    // prefill words 64 to 127, then a mixed burst under random stalls
    for (int i = 0; i < 16; i++) send_req(1'b0, 64 + 4 * i, '1, rand_wide());
    stall_en <= 1'b1;
    for (int i = 0; i < NB_RAND; i++) begin
      r = next_rand();
      w = 64 + (r >> 8) % 61;
      send_req(r[31], w, wide_mem_pkg::wide_be_t'(next_rand() >> 8), rand_wide());
    end
    stall_en <= 1'b0;

    // back-to-back reads without stalls
    for (int i = 0; i < 8; i++) send_req(1'b1, 64 + 7 * i, '0, '0);

    // clear while idle, then a normal access
    wait_drain();
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    @(negedge clk_i);
    if (r_valid_o || !gnt_o) begin
      errors++;
      $display("subsystem not idle after clear");
    end
    send_req(1'b0, 40, '1, rand_wide());
    send_req(1'b1, 40, '0, '0);

    wait_cyc = 0;
    while (exp_rd_q.size() != 0 && wait_cyc < 50) begin
      @(negedge clk_i);
      wait_cyc++;
    end
    if (exp_rd_q.size() != 0) begin
      errors++;
      $display("%0d responses never arrived", exp_rd_q.size());
    end

    $display("read checks: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+verilog
verilog/wide_mem_pkg.sv
verilog/wide_req_fifo.sv
verilog/router_reorder.sv
verilog/wide_router.sv
verilog/tcdm_bank.sv
verilog/wide_mem_subsystem.sv
dv/wide_mem_sva.sv
dv/tb_wide_mem.sv

// File: Makefile
# Verilator flow for the wide memory subsystem

TOOL       := verilator
TOP        := tb_wide_mem
FLIST      := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)
	$(TOOL) $(LINT_FLAGS) --top-module wide_mem_subsystem -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST) | grep -v '^+')
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
